// ==== bench/mem_subsys_checker.sv ====
`timescale 1ns/10ps

// reference memory and in-order result comparison
module mem_subsys_checker import mem_sys_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  fetch_valid,
    input  addr_t fetch_addr,
    input  logic  fetch_ready,
    input  logic  fetch_result_valid,
    input  word_t fetch_result,
    input  logic  data_valid,
    input  logic  data_write,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  logic  data_ready,
    input  logic  load_result_valid,
    input  word_t load_result,
    output int    check_errors,
    output int    pending
);

    word_t model [MEM_WORDS]; // what memory should hold
    word_t fetch_q [$];       // expected words, oldest first
    word_t load_q [$];
    string test_name = "none";

    task automatic begin_test(input string name);
        test_name = name;
    endtask

    task automatic compare(input string port, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: %s result expected %h actual %h",
                     test_name, port, expected, actual);
            check_errors++;
        end
    endtask

    task automatic stray_result(input string port);
        $display("%s: %s result pulse with no request outstanding", test_name, port);
        check_errors++;
    endtask

    initial begin
        check_errors = 0;
        pending      = 0;
    end

    always @(posedge clock) begin
        if (reset) begin
            fetch_q.delete();
            load_q.delete();
        end else begin
            if (fetch_result_valid) begin
                if (fetch_q.size() == 0) stray_result("fetch");
                else compare("fetch", fetch_q.pop_front(), fetch_result);
            end
            if (load_result_valid) begin
                if (load_q.size() == 0) stray_result("load");
                else compare("load", load_q.pop_front(), load_result);
            end
            // word index is address bits 12:3
            if (fetch_valid && fetch_ready) fetch_q.push_back(model[fetch_addr[12:3]]);
            if (data_valid && data_ready) begin
                if (data_write) model[data_addr[12:3]] = data_wdata;
                else load_q.push_back(model[data_addr[12:3]]);
            end
        end
        pending <= fetch_q.size() + load_q.size();
    end

endmodule

// ==== bench/mem_subsys_sva.sv ====
`timescale 1ns/10ps

// arbiter checks, bound into mem_arbiter
module mem_subsys_sva import mem_sys_pkg::*; (
    input logic     clock,
    input logic     reset,
    input mem_tag_t icache_response,
    input mem_tag_t dcache_response,
    input bus_cmd_t icache_command,
    input bus_cmd_t dcache_command
);

    // a nonzero response belongs to the side granted last cycle
    dcache_owner: assert property (@(posedge clock) disable iff (reset)
        (dcache_response != '0) |-> $past(dcache_command != BUS_NONE))
        else $error("dcache got a response for a command it did not issue");

    icache_owner: assert property (@(posedge clock) disable iff (reset)
        (icache_response != '0) |->
            $past((icache_command != BUS_NONE) && (dcache_command == BUS_NONE)))
        else $error("icache got a response while the dcache held the bus");

    // data side always wins
    data_priority: assert property (@(posedge clock) disable iff (reset)
        (dcache_command != BUS_NONE) |=>
            (dcache_response != '0) && (icache_response == '0))
        else $error("dcache command was not the one memory accepted");

    quiet_after_reset: assert property (@(posedge clock)
        reset |=> (icache_response == '0) && (dcache_response == '0))
        else $error("response nonzero in the cycle after reset");

endmodule

// ==== bench/mem_subsys_tb.sv ====
`timescale 1ns/10ps

module mem_subsys_tb import mem_sys_pkg::*; ();

    localparam int WAIT_LIMIT = 200; // cycles allowed per wait loop

    logic  clock;
    logic  reset;
    logic  fetch_valid;
    addr_t fetch_addr;
    logic  fetch_ready;
    logic  fetch_result_valid;
    word_t fetch_result;
    logic  data_valid;
    logic  data_write;
    addr_t data_addr;
    word_t data_wdata;
    logic  data_ready;
    logic  load_result_valid;
    word_t load_result;
    int    check_errors;
    int    pending;

    logic [31:0] lfsr;
    string       test_name;
    int          tb_errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    mem_subsys_top mem_subsys_top_i (.*);
    mem_subsys_checker check_i (.*);

    bind mem_arbiter mem_subsys_sva sva_i (
        .clock           (clock),
        .reset           (reset),
        .icache_response (icache_bus.response),
        .dcache_response (dcache_bus.response),
        .icache_command  (icache_bus.command),
        .dcache_command  (dcache_bus.command)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // galois lfsr, one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);
        end
        return v;
    endfunction

    // one of 32 words above base, random low byte bits
    function automatic addr_t random_addr(input int base);
        addr_t w;
        addr_t low;
        w   = addr_t'(base) + addr_t'(rand_bits(5));
        low = addr_t'(rand_bits(3));
        return (w << 3) | low;
    endfunction

    task automatic wait_expired(input string what);
        $display("TIMEOUT in %s: waited %0d cycles for %s", test_name, WAIT_LIMIT, what);
        $display("Simulation FAILED");
        $finish;
    endtask

    // valid stays up until the handshake edge
    task automatic request(input logic is_fetch, input logic write,
                           input addr_t a, input word_t d);
        int n;
        n = 0;
        if (is_fetch) begin
            fetch_valid <= 1'b1;
            fetch_addr  <= a;
        end else begin
            data_valid <= 1'b1;
            data_write <= write;
            data_addr  <= a;
            data_wdata <= d;
        end
        do begin
            @(posedge clock);
            n++;
            if (n > WAIT_LIMIT) wait_expired("the request handshake");
        end while (!(is_fetch ? fetch_ready : data_ready));
        if (is_fetch) fetch_valid <= 1'b0;
        else data_valid <= 1'b0;
    endtask

    // n counts cycles from acceptance to result pulse
    task automatic access(input logic is_fetch, input addr_t a, output int n);
        request(is_fetch, 1'b0, a, '0);
        n = 0;
        do begin
            @(posedge clock);
            n++;
            if (n > WAIT_LIMIT) wait_expired("a result pulse");
        end while (!(is_fetch ? fetch_result_valid : load_result_valid));
    endtask

    task automatic check_latency(input string what, input int expected, input int actual);
        if (actual != expected) begin
            $display("FAIL %s: %s latency expected %0d actual %0d",
                     test_name, what, expected, actual);
            tb_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        check_i.begin_test(name);
        errors_at_start = check_errors + tb_errors;
    endtask

    task automatic end_test();
        int n;
        int found;
        n = 0;
        do begin
            @(posedge clock);
            n++;
            if (n > WAIT_LIMIT) wait_expired("the outstanding results");
        end while (pending != 0);
        found = check_errors + tb_errors - errors_at_start;
        tests_run++;
        if (found != 0) tests_failed++;
        $display("test %s finished, %0d errors", test_name, found);
    endtask

    initial begin
        addr_t a;
        word_t d;
        logic  w;
        int    n;
        int    total;
        addr_t f_addr [150];
        addr_t d_addr [150];
        logic  d_write [150];
        word_t d_data [150];

        lfsr         = 32'h47f7;
        tb_errors    = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        data_valid   = 1'b0;
        data_write   = 1'b0;
        data_addr    = '0;
        data_wdata   = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        start_test("preload");
        for (int i = 0; i < 64; i++) begin
            a = addr_t'((i < 32) ? i : i + 480) << 3; // words 0-31 and 512-543
            d = rand_bits(64);
            request(1'b0, 1'b1, a, d);
            request(1'b0, 1'b0, a, '0);
        end
        end_test();

        start_test("fetch_sweep");
        a = random_addr(0);
        for (int i = 0; i < 200; i++) begin
            if (rand_bits(2) != 0) a = random_addr(0); // otherwise repeat for a hit
            request(1'b1, 1'b0, a, '0);
        end
        end_test();

        start_test("data_mix");
        for (int i = 0; i < 200; i++) begin
            w = 1'(rand_bits(1));
            a = random_addr(512);
            d = rand_bits(64);
            request(1'b0, w, a, d);
        end
        end_test();

        start_test("contention");
        for (int i = 0; i < 150; i++) begin
            f_addr[i]  = random_addr(0);
            d_write[i] = 1'(rand_bits(1));
            d_addr[i]  = random_addr(512);
            d_data[i]  = rand_bits(64);
        end
        fork
            for (int i = 0; i < 150; i++)
                request(1'b1, 1'b0, f_addr[i], '0);
            for (int j = 0; j < 150; j++)
                request(1'b0, d_write[j], d_addr[j], d_data[j]);
        join
        end_test();

        start_test("hit_timing");
        a = random_addr(512);
        access(1'b0, a, n);
        access(1'b0, a, n);
        check_latency("load hit", 1, n);
        a = random_addr(0);
        access(1'b1, a, n);
        access(1'b1, a, n);
        check_latency("fetch hit", 1, n);
        end_test();

        start_test("reset_state");
        for (int k = 0; k < 4; k++) begin
            access(1'b0, addr_t'(512 + 3 * k) << 3, n); // cached before the reset
            access(1'b1, addr_t'(1 + 3 * k) << 3, n);
        end
        reset <= 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        if (!fetch_ready || !data_ready) begin
            $display("%s: a ready was low right after reset", test_name);
            tb_errors++;
        end
        repeat (10) begin
            @(posedge clock);
            if (fetch_result_valid || load_result_valid) begin
                $display("%s: result pulse appeared with no request made", test_name);
                tb_errors++;
            end
        end
        for (int k = 0; k < 4; k++) begin
            access(1'b0, addr_t'(512 + 3 * k) << 3, n); // distinct lines
            check_latency("first load", MEM_LATENCY + 3, n);
            access(1'b1, addr_t'(1 + 3 * k) << 3, n);
            check_latency("first fetch", MEM_LATENCY + 3, n);
        end
        end_test();

        total = check_errors + tb_errors;
        $display("%0d tests, %0d with errors, %0d errors in total",
                 tests_run, tests_failed, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
src/mem_sys_pkg.sv
src/mem_bus_if.sv
src/miss_fsm.sv
src/mem_arbiter.sv
src/tagged_memory.sv
src/icache.sv
src/dcache.sv
src/mem_subsys_top.sv
bench/mem_subsys_sva.sv
bench/mem_subsys_checker.sv
bench/mem_subsys_tb.sv

// ==== src/dcache.sv ====
`timescale 1ns/10ps

// write-through, no write-allocate
module dcache import mem_sys_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       data_valid,
    input  logic       data_write,
    input  addr_t      data_addr,
    input  word_t      data_wdata,
    output logic       data_ready,
    output logic       load_result_valid,
    output word_t      load_result,
    mem_bus_if.client  bus
);

    logic [CACHE_LINES-1:0] valid_q;
    line_tag_t              tag_mem [CACHE_LINES];
    word_t                  data_mem [CACHE_LINES];
    addr_t                  req_addr;
    word_t                  req_wdata;
    logic                   req_write;
    logic                   req_pending;
    index_t                 req_index;
    logic                   hit;
    logic                   accept;
    logic                   start;
    logic                   issue, fill, done, idle;

    assign req_index  = line_index(req_addr);
    assign hit        = valid_q[req_index] && (tag_mem[req_index] == line_tag(req_addr));
    assign data_ready = idle && !req_pending;
    assign accept     = data_valid && data_ready;
    assign start      = req_pending && (req_write || !hit); // every store goes out

    miss_fsm miss_fsm_i (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .is_store (req_write),
        .response (bus.response),
        .rtag     (bus.rtag),
        .issue    (issue),
        .fill     (fill),
        .done     (done),
        .idle     (idle)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            req_pending <= 1'b0;
            valid_q     <= '0;
        end else begin
            req_pending <= accept;
            if (fill) valid_q[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr  <= data_addr;
            req_write <= data_write;
            req_wdata <= data_wdata;
        end
        if (fill) begin
            tag_mem[req_index]  <= line_tag(req_addr);
            data_mem[req_index] <= bus.rdata;
        end else if (req_pending && req_write && hit) begin
            data_mem[req_index] <= req_wdata; // store hit keeps line current
        end
    end

    // done also marks store completion, which has no result
    assign load_result_valid = !req_write && ((req_pending && hit) || done);
    assign load_result       = done ? bus.rdata : data_mem[req_index];

    always_comb begin
        bus.command = BUS_NONE;
        if (issue) bus.command = req_write ? BUS_STORE : BUS_LOAD;
    end

    assign bus.addr  = req_addr;
    assign bus.wdata = req_wdata;

endmodule

// ==== src/icache.sv ====
`timescale 1ns/10ps

module icache import mem_sys_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       fetch_valid,
    input  addr_t      fetch_addr,
    output logic       fetch_ready,
    output logic       fetch_result_valid,
    output word_t      fetch_result,
    mem_bus_if.client  bus
);

    logic [CACHE_LINES-1:0] valid_q;
    line_tag_t              tag_mem [CACHE_LINES];
    word_t                  data_mem [CACHE_LINES];
    addr_t                  req_addr;
    logic                   req_pending; // lookup happens this cycle
    index_t                 req_index;
    logic                   hit;
    logic                   accept;
    logic                   issue, fill, done, idle;

    assign req_index   = line_index(req_addr);
    assign hit         = valid_q[req_index] && (tag_mem[req_index] == line_tag(req_addr));
    assign fetch_ready = idle && !req_pending;
    assign accept      = fetch_valid && fetch_ready;

    miss_fsm miss_fsm_i (
        .clock    (clock),
        .reset    (reset),
        .start    (req_pending && !hit),
        .is_store (1'b0),
        .response (bus.response),
        .rtag     (bus.rtag),
        .issue    (issue),
        .fill     (fill),
        .done     (done),
        .idle     (idle)
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            req_pending <= 1'b0;
            valid_q     <= '0;
        end else begin
            req_pending <= accept;
            if (fill) valid_q[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) req_addr <= fetch_addr;
        if (fill) begin
            tag_mem[req_index]  <= line_tag(req_addr);
            data_mem[req_index] <= bus.rdata;
        end
    end

    assign fetch_result_valid = (req_pending && hit) || done;
    assign fetch_result       = done ? bus.rdata : data_mem[req_index]; // bypass on fill

    assign bus.command = issue ? BUS_LOAD : BUS_NONE;
    assign bus.addr    = req_addr;
    assign bus.wdata   = '0;

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/10ps

// data side has priority, responses follow last cycle's grant
module mem_arbiter import mem_sys_pkg::*; (
    input logic       clock,
    input logic       reset,
    mem_bus_if.host   icache_bus,
    mem_bus_if.host   dcache_bus,
    mem_bus_if.client mem_bus
);

    logic d_grant;
    logic d_grant_q; // dcache owned the bus last cycle

    assign d_grant = (dcache_bus.command != BUS_NONE);

    always_comb begin
        if (d_grant) begin
            mem_bus.command = dcache_bus.command;
            mem_bus.addr    = dcache_bus.addr;
            mem_bus.wdata   = dcache_bus.wdata;
        end else begin
            mem_bus.command = icache_bus.command;
            mem_bus.addr    = icache_bus.addr;
            mem_bus.wdata   = '0; // icache never stores
        end
    end

    // response goes to whoever issued last cycle
    assign dcache_bus.response = d_grant_q ? mem_bus.response : '0;
    assign icache_bus.response = d_grant_q ? '0 : mem_bus.response;

    // load data is broadcast, tags sort it out
    assign dcache_bus.rdata = mem_bus.rdata;
    assign dcache_bus.rtag  = mem_bus.rtag;
    assign icache_bus.rdata = mem_bus.rdata;
    assign icache_bus.rtag  = mem_bus.rtag;

    always_ff @(posedge clock) begin
        if (reset) begin
            d_grant_q <= 1'b0;
        end else begin
            d_grant_q <= d_grant;
        end
    end

endmodule

// ==== src/mem_bus_if.sv ====
`timescale 1ns/10ps

// one client's path to memory
interface mem_bus_if import mem_sys_pkg::*; ();

    bus_cmd_t command;
    addr_t    addr;
    word_t    wdata;    // store data only
    mem_tag_t response; // accept tag, zero when not accepted
    word_t    rdata;
    mem_tag_t rtag;     // tag of the load data on rdata

    modport client (
        output command, addr, wdata,
        input  response, rdata, rtag
    );

    modport host (
        input  command, addr, wdata,
        output response, rdata, rtag
    );

endinterface

// ==== src/mem_subsys_top.sv ====
`timescale 1ns/10ps

module mem_subsys_top import mem_sys_pkg::*; (
    input  logic  clock,
    input  logic  reset,

    // fetch port
    input  logic  fetch_valid,
    input  addr_t fetch_addr,
    output logic  fetch_ready,
    output logic  fetch_result_valid,
    output word_t fetch_result,

    // data port
    input  logic  data_valid,
    input  logic  data_write,
    input  addr_t data_addr,
    input  word_t data_wdata,
    output logic  data_ready,
    output logic  load_result_valid,
    output word_t load_result
);

    mem_bus_if ibus ();
    mem_bus_if dbus ();
    mem_bus_if mbus (); // arbiter to memory

    icache icache_i (
        .clock              (clock),
        .reset              (reset),
        .fetch_valid        (fetch_valid),
        .fetch_addr         (fetch_addr),
        .fetch_ready        (fetch_ready),
        .fetch_result_valid (fetch_result_valid),
        .fetch_result       (fetch_result),
        .bus                (ibus.client)
    );

    dcache dcache_i (
        .clock             (clock),
        .reset             (reset),
        .data_valid        (data_valid),
        .data_write        (data_write),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_ready        (data_ready),
        .load_result_valid (load_result_valid),
        .load_result       (load_result),
        .bus               (dbus.client)
    );

    mem_arbiter mem_arbiter_i (
        .clock      (clock),
        .reset      (reset),
        .icache_bus (ibus.host),
        .dcache_bus (dbus.host),
        .mem_bus    (mbus.client)
    );

    tagged_memory tagged_memory_i (
        .clock (clock),
        .reset (reset),
        .bus   (mbus.host)
    );

endmodule

// ==== src/mem_sys_pkg.sv ====
package mem_sys_pkg;

    typedef logic [31:0] addr_t;    // byte address, low 3 bits ignored
    typedef logic [63:0] word_t;
    typedef logic [3:0]  mem_tag_t; // zero means no response
    typedef logic [1:0]  bus_cmd_t;

    localparam bus_cmd_t BUS_NONE  = 2'd0;
    localparam bus_cmd_t BUS_LOAD  = 2'd1;
    localparam bus_cmd_t BUS_STORE = 2'd2;

    localparam int MEM_LATENCY    = 4;    // tag response to load data
    localparam int MEM_WORDS      = 1024;
    localparam int CACHE_LINES    = 16;
    localparam int WORD_LSB       = 3;    // 8 bytes per word
    localparam int INDEX_BITS     = $clog2(CACHE_LINES);
    localparam int MEM_INDEX_BITS = $clog2(MEM_WORDS);

    typedef logic [INDEX_BITS-1:0]                index_t;
    typedef logic [MEM_INDEX_BITS-INDEX_BITS-1:0] line_tag_t;
    typedef logic [MEM_INDEX_BITS-1:0]            mem_index_t;

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT_RESP, WAIT_DATA} miss_state_t;

    function automatic mem_index_t word_index(addr_t addr);
        return addr[WORD_LSB +: MEM_INDEX_BITS];
    endfunction

    function automatic index_t line_index(addr_t addr);
        return addr[WORD_LSB +: INDEX_BITS];
    endfunction

    function automatic line_tag_t line_tag(addr_t addr);
        return addr[WORD_LSB + INDEX_BITS +: $bits(line_tag_t)]; // bits 12:7
    endfunction

endpackage

// ==== src/miss_fsm.sv ====
`timescale 1ns/10ps

module miss_fsm import mem_sys_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     start,
    input  logic     is_store,
    input  mem_tag_t response,
    input  mem_tag_t rtag,
    output logic     issue,
    output logic     fill,
    output logic     done,
    output logic     idle
);

    miss_state_t state;
    miss_state_t next_state;
    mem_tag_t    kept_tag; // tag of the outstanding load
    logic        accepted;
    logic        data_here;

    assign accepted  = (state == WAIT_RESP) && (response != '0);
    assign data_here = (state == WAIT_DATA) && (rtag == kept_tag);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) next_state = ISSUE;
            end
            ISSUE: next_state = WAIT_RESP;
            WAIT_RESP: begin
                if (response == '0) begin
                    next_state = ISSUE; // lost arbitration, try again
                end else if (is_store) begin
                    next_state = IDLE;
                end else begin
                    next_state = WAIT_DATA;
                end
            end
            WAIT_DATA: begin
                if (data_here) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (accepted) kept_tag <= response;
    end

    assign issue = (state == ISSUE);
    assign fill  = data_here;
    assign done  = data_here || (accepted && is_store); // store ends at its response
    assign idle  = (state == IDLE);

endmodule

// ==== src/tagged_memory.sv ====
`timescale 1ns/10ps

module tagged_memory import mem_sys_pkg::*; (
    input logic     clock,
    input logic     reset,
    mem_bus_if.host bus
);

    word_t      storage [MEM_WORDS];
    mem_tag_t   next_tag;
    mem_tag_t   response_q;
    logic       load_q;   // accepted command was a load
    word_t      read_q;
    word_t      data_chain [MEM_LATENCY];
    mem_tag_t   tag_chain [MEM_LATENCY];
    logic       accept;
    mem_index_t idx;

    assign accept = (bus.command != BUS_NONE);
    assign idx    = word_index(bus.addr);

    // storage and load data path
    always_ff @(posedge clock) begin
        if (bus.command == BUS_STORE) storage[idx] <= bus.wdata;
        read_q        <= storage[idx];
        data_chain[0] <= read_q;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_chain[i] <= data_chain[i-1];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag   <= 4'd1;
            response_q <= '0;
            load_q     <= 1'b0;
            for (int i = 0; i < MEM_LATENCY; i++) begin
                tag_chain[i] <= '0;
            end
        end else begin
            if (accept) begin
                next_tag <= (next_tag == '1) ? 4'd1 : next_tag + 4'd1; // skip zero
            end
            response_q   <= accept ? next_tag : '0;
            load_q       <= (bus.command == BUS_LOAD);
            tag_chain[0] <= load_q ? response_q : '0; // stores get no data
            for (int i = 1; i < MEM_LATENCY; i++) begin
                tag_chain[i] <= tag_chain[i-1];
            end
        end
    end

    assign bus.response = response_q;
    assign bus.rdata    = data_chain[MEM_LATENCY-1];
    assign bus.rtag     = tag_chain[MEM_LATENCY-1];

endmodule
